// ==== tb.f ====
hw/axi3_pkg.sv
hw/axi3_mem_ram.sv
hw/axi3_wr_path.sv
hw/axi3_rd_path.sv
hw/axi3_mem.sv
bench/axi3_mem_checker.sv
bench/axi3_mem_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the AXI3 memory testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module axi3_mem_tb -o axi3_mem_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/axi3_mem_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    exit 1
fi
exit 0

// ==== bench/axi3_mem_tb.sv ====
module axi3_mem_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import axi3_pkg::*;

    localparam int NAME_CHARS = 16;
    localparam int CLK_HALF = 20;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY = 2;
    localparam int NUM_OPS = 16;
    localparam logic [15:0] LFSR_SEED = 16'd84;

    typedef struct packed {
        logic [8*NAME_CHARS-1:0] name;
        logic                    is_write;
        logic [ID_WID-1:0]       id;
        logic [ADDR_WID-1:0]     addr;
        logic [LEN_WID-1:0]      len;
        axburst_t                burst;
        logic [DATA_BYTE_WID-1:0] strb;
        logic                    stall;
    } op_t;

    // name, write, id, addr, len, burst, strobe, stall
    localparam op_t OPS [NUM_OPS] = '{
        '{"single_wr",     1'b1, 4'h1, 16'h0100, 4'd0,  BURST_INCR,  4'hf, 1'b0},
        '{"single_rd",     1'b0, 4'h2, 16'h0100, 4'd0,  BURST_INCR,  4'hf, 1'b0},
        '{"partial_wr",    1'b1, 4'h3, 16'h0100, 4'd0,  BURST_INCR,  4'h5, 1'b0},
        '{"partial_rd",    1'b0, 4'h4, 16'h0100, 4'd0,  BURST_INCR,  4'hf, 1'b0},
        '{"incr16_wr",     1'b1, 4'h5, 16'h0200, 4'd15, BURST_INCR,  4'hf, 1'b0},
        '{"incr16_rd",     1'b0, 4'h6, 16'h0200, 4'd15, BURST_INCR,  4'hf, 1'b0},
        '{"fixed_init",    1'b1, 4'h7, 16'h0300, 4'd0,  BURST_INCR,  4'hf, 1'b0},
        '{"fixed_wr",      1'b1, 4'h8, 16'h0300, 4'd5,  BURST_FIXED, 4'h6, 1'b0},
        '{"fixed_rd",      1'b0, 4'h9, 16'h0300, 4'd3,  BURST_FIXED, 4'hf, 1'b0},
        '{"wrap_wr",       1'b1, 4'ha, 16'h0200, 4'd3,  BURST_WRAP,  4'hf, 1'b0},
        '{"wrap_check_rd", 1'b0, 4'hb, 16'h0200, 4'd3,  BURST_INCR,  4'hf, 1'b0},
        '{"wrap_rd",       1'b0, 4'hc, 16'h0200, 4'd3,  BURST_WRAP,  4'hf, 1'b0},
        '{"stall_wr",      1'b1, 4'hd, 16'h0400, 4'd15, BURST_INCR,  4'hf, 1'b1},
        '{"stall_part_wr", 1'b1, 4'he, 16'h0408, 4'd7,  BURST_INCR,  4'h9, 1'b1},
        '{"stall_rd",      1'b0, 4'hf, 16'h0400, 4'd15, BURST_INCR,  4'hf, 1'b1},
        '{"alias_rd",      1'b0, 4'h1, 16'h1100, 4'd0,  BURST_INCR,  4'hf, 1'b0}
    };

    logic                     axi3_if;
    logic                     srst;
    logic                     awvalid;
    logic                     awready;
    logic [ID_WID-1:0]        awid;
    logic [ADDR_WID-1:0]      awaddr;
    logic [LEN_WID-1:0]       awlen;
    axburst_t                 awburst;
    logic                     wvalid;
    logic                     wready;
    logic [ID_WID-1:0]        wid;
    logic [DATA_WID-1:0]      wdata;
    logic [DATA_BYTE_WID-1:0] wstrb;
    logic                     wlast;
    logic                     bvalid;
    logic                     bready;
    logic [ID_WID-1:0]        bid;
    resp_t                    bresp;
    logic                     arvalid;
    logic                     arready;
    logic [ID_WID-1:0]        arid;
    logic [ADDR_WID-1:0]      araddr;
    logic [LEN_WID-1:0]       arlen;
    axburst_t                 arburst;
    logic                     rvalid;
    logic                     rready;
    logic [ID_WID-1:0]        rid;
    logic [DATA_WID-1:0]      rdata;
    resp_t                    rresp;
    logic                     rlast;

    logic [8*NAME_CHARS-1:0]  test_name;
    logic                     run_done;
    int                       error_count;
    int                       tests_done;
    logic [15:0]              lfsr;

    axi3_mem axi3_mem_inst (.*);

    axi3_mem_checker #(.NAME_CHARS(NAME_CHARS)) axi3_mem_checker_inst (.*);

    always #(CLK_HALF) axi3_if = ~axi3_if;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic pick_ready(input logic stall, output logic ready);
        logic [31:0] bits;
        ready = 1'b1;
        if (stall) begin
            draw_bits(1, bits);
            ready = bits[0];
        end
    endtask

    function automatic int watchdog_cycles();
        int total;
        total = 0;
        for (int i = 0; i < NUM_OPS; i++) begin
            total += (int'(OPS[i].len) + 1) * 4 + WR_LATENCY + RD_LATENCY + 20;
        end
        return total;
    endfunction

    task automatic write_burst(input op_t op);
        logic [31:0] word;
        logic        ready_bit;
        logic        got_b;
        int          beat;
        awvalid = 1'b1;
        awid    = op.id;
        awaddr  = op.addr;
        awlen   = op.len;
        awburst = op.burst;
        do @(negedge axi3_if); while (!awready);
        @(posedge axi3_if);
        #(DRIVE_DELAY);
        awvalid = 1'b0;
        for (beat = 0; beat <= int'(op.len); beat++) begin
            draw_bits(32, word);
            wvalid = 1'b1;
            wid    = op.id;
            wdata  = word;
            wstrb  = op.strb;
            wlast  = (beat == int'(op.len));
            do @(negedge axi3_if); while (!wready);
            @(posedge axi3_if);
            #(DRIVE_DELAY);
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
        got_b  = 1'b0;
        while (!got_b) begin
            pick_ready(op.stall, ready_bit);
            bready = ready_bit;
            @(negedge axi3_if);
            got_b = bvalid && bready;
            @(posedge axi3_if);
            #(DRIVE_DELAY);
        end
        bready = 1'b0;
    endtask

    task automatic read_burst(input op_t op);
        logic ready_bit;
        logic got_last;
        arvalid = 1'b1;
        arid    = op.id;
        araddr  = op.addr;
        arlen   = op.len;
        arburst = op.burst;
        do @(negedge axi3_if); while (!arready);
        @(posedge axi3_if);
        #(DRIVE_DELAY);
        arvalid  = 1'b0;
        got_last = 1'b0;
        while (!got_last) begin
            pick_ready(op.stall, ready_bit);
            rready = ready_bit;
            @(negedge axi3_if);
            got_last = rvalid && rready && rlast;
            @(posedge axi3_if);
            #(DRIVE_DELAY);
        end
        rready = 1'b0;
    endtask

    initial begin
        int op_idx;
        axi3_if   = 1'b0;
        srst      = 1'b1;
        awvalid   = 1'b0;
        awid      = '0;
        awaddr    = '0;
        awlen     = '0;
        awburst   = BURST_INCR;
        wvalid    = 1'b0;
        wid       = '0;
        wdata     = '0;
        wstrb     = '0;
        wlast     = 1'b0;
        bready    = 1'b0;
        arvalid   = 1'b0;
        arid      = '0;
        araddr    = '0;
        arlen     = '0;
        arburst   = BURST_INCR;
        rready    = 1'b0;
        test_name = '0;
        run_done  = 1'b0;
        lfsr      = LFSR_SEED;
        repeat (RESET_CYCLES) @(posedge axi3_if);
        #(DRIVE_DELAY);
        srst = 1'b0;
        for (op_idx = 0; op_idx < NUM_OPS; op_idx++) begin
            test_name = OPS[op_idx].name;
            if (OPS[op_idx].is_write) begin
                write_burst(OPS[op_idx]);
            end else begin
                read_burst(OPS[op_idx]);
            end
        end
        run_done = 1'b1;
        @(negedge axi3_if);
        if (error_count == 0 && tests_done == NUM_OPS) begin
            $display("=== PASS ===");
        end else begin
            if (tests_done != NUM_OPS) begin
                $display("Only %0d of %0d tests completed", tests_done, NUM_OPS);
            end
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog
    initial begin
        int limit;
        limit = watchdog_cycles();
        repeat (limit) @(posedge axi3_if);
        $display("Timeout: the run did not finish within %0d clock cycles", limit);
        $display("=== FAIL ===");
        $finish;
    end

endmodule : axi3_mem_tb

// ==== bench/axi3_mem_checker.sv ====
module axi3_mem_checker #(
    parameter int NAME_CHARS = 16
) (
    input  logic                                axi3_if,
    input  logic                                srst,
    input  logic                                awvalid,
    input  logic                                awready,
    input  logic [axi3_pkg::ID_WID-1:0]         awid,
    input  logic [axi3_pkg::ADDR_WID-1:0]       awaddr,
    input  axi3_pkg::axburst_t                  awburst,
    input  logic                                wvalid,
    input  logic                                wready,
    input  logic [axi3_pkg::DATA_WID-1:0]       wdata,
    input  logic [axi3_pkg::DATA_BYTE_WID-1:0]  wstrb,
    input  logic                                wlast,
    input  logic                                bvalid,
    input  logic                                bready,
    input  logic [axi3_pkg::ID_WID-1:0]         bid,
    input  axi3_pkg::resp_t                     bresp,
    input  logic                                arvalid,
    input  logic                                arready,
    input  logic [axi3_pkg::ID_WID-1:0]         arid,
    input  logic [axi3_pkg::ADDR_WID-1:0]       araddr,
    input  logic [axi3_pkg::LEN_WID-1:0]        arlen,
    input  axi3_pkg::axburst_t                  arburst,
    input  logic                                rvalid,
    input  logic                                rready,
    input  logic [axi3_pkg::ID_WID-1:0]         rid,
    input  logic [axi3_pkg::DATA_WID-1:0]       rdata,
    input  axi3_pkg::resp_t                     rresp,
    input  logic                                rlast,
    input  logic [8*NAME_CHARS-1:0]             test_name,
    input  logic                                run_done,
    output int                                  error_count,
    output int                                  tests_done
);
    timeunit 1ns;
    timeprecision 100ps;

    import axi3_pkg::*;

    // Byte-accurate reference of the RAM indexed by address bits 11:2
    logic [DATA_WID-1:0]    model_mem [MEM_WORDS];
    logic [MEM_IDX_WID-1:0] idx;
    int                     lane;
    int                     test_errs;

    logic [ID_WID-1:0]      w_id;
    logic [ADDR_WID-1:0]    w_addr;
    axburst_t               w_burst;
    logic                   b_lat_run;
    int                     b_lat_cnt;
    logic                   w_busy;
    logic                   w_data;

    logic [ID_WID-1:0]      r_id;
    logic [ADDR_WID-1:0]    r_addr;
    logic [LEN_WID-1:0]     r_len;
    axburst_t               r_burst;
    int                     r_beat;
    logic                   r_lat_run;
    int                     r_lat_cnt;
    logic                   r_busy;
    logic [DATA_WID-1:0]    exp_data;
    resp_t                  exp_resp;

    initial begin
        error_count = 0;
        tests_done  = 0;
        test_errs   = 0;
        b_lat_run   = 1'b0;
        r_lat_run   = 1'b0;
        w_busy      = 1'b0;
        w_data      = 1'b0;
        r_busy      = 1'b0;
    end

    task automatic note_error();
        error_count++;
        test_errs++;
    endtask

    task automatic close_test();
        if (test_errs == 0) begin
            $display("%0s: ok", test_name);
        end else begin
            $display("%0s: %0d mismatches", test_name, test_errs);
        end
        tests_done++;
        test_errs = 0;
    endtask

    // Sampled mid-cycle where inputs and outputs have settled
    always @(negedge axi3_if) begin
        if (!srst) begin
            // Ready outputs follow the burst phases seen so far
            if (awready != !w_busy) begin
                $display("ERROR %0s awready: expected %0b, actual %0b",
                         test_name, !w_busy, awready);
                note_error();
            end
            if (wready != w_data) begin
                $display("ERROR %0s wready: expected %0b, actual %0b",
                         test_name, w_data, wready);
                note_error();
            end
            if (arready != !r_busy) begin
                $display("ERROR %0s arready: expected %0b, actual %0b",
                         test_name, !r_busy, arready);
                note_error();
            end
            if (b_lat_run) begin
                b_lat_cnt++;
                if (bvalid) begin
                    b_lat_run = 1'b0;
                    if (b_lat_cnt != WR_LATENCY) begin
                        $display("ERROR %0s bvalid latency: expected %0d, actual %0d",
                                 test_name, WR_LATENCY, b_lat_cnt);
                        note_error();
                    end
                end
            end
            if (r_lat_run) begin
                r_lat_cnt++;
                if (rvalid) begin
                    r_lat_run = 1'b0;
                    if (r_lat_cnt != RD_LATENCY + 2) begin
                        $display("ERROR %0s rvalid latency: expected %0d, actual %0d",
                                 test_name, RD_LATENCY + 2, r_lat_cnt);
                        note_error();
                    end
                end
            end
            if (awvalid && awready) begin
                w_id    = awid;
                w_addr  = awaddr;
                w_burst = awburst;
                w_busy  = 1'b1;
                w_data  = 1'b1;
            end
            if (wvalid && wready) begin
                // WRAP beats are refused and never reach memory
                if (w_burst == BURST_FIXED || w_burst == BURST_INCR) begin
                    idx = w_addr[BYTE_SEL_WID +: MEM_IDX_WID];
                    for (lane = 0; lane < DATA_BYTE_WID; lane++) begin
                        if (wstrb[lane]) begin
                            model_mem[idx][lane*8 +: 8] = wdata[lane*8 +: 8];
                        end
                    end
                end
                if (w_burst == BURST_INCR) begin
                    w_addr = w_addr + ADDR_WID'(DATA_BYTE_WID);
                end
                if (wlast) begin
                    b_lat_run = 1'b1;
                    b_lat_cnt = 0;
                    w_data    = 1'b0;
                end
            end
            if (bvalid && bready) begin
                exp_resp = (w_burst == BURST_WRAP) ? RESP_SLVERR : RESP_OKAY;
                if (bid != w_id) begin
                    $display("ERROR %0s bid: expected %0h, actual %0h", test_name, w_id, bid);
                    note_error();
                end
                if (bresp != exp_resp) begin
                    $display("ERROR %0s bresp: expected %0d, actual %0d",
                             test_name, exp_resp, bresp);
                    note_error();
                end
                w_busy = 1'b0;
                close_test();
            end
            if (arvalid && arready) begin
                r_id      = arid;
                r_addr    = araddr;
                r_len     = arlen;
                r_burst   = arburst;
                r_beat    = 0;
                r_lat_run = 1'b1;
                r_lat_cnt = 0;
                r_busy    = 1'b1;
            end
            if (rvalid && rready) begin
                idx = r_addr[BYTE_SEL_WID +: MEM_IDX_WID];
                if (r_burst == BURST_WRAP) begin
                    exp_data = '0;
                    exp_resp = RESP_SLVERR;
                end else begin
                    exp_data = model_mem[idx];
                    exp_resp = RESP_OKAY;
                end
                if (r_beat > int'(r_len)) begin
                    $display("%0s: extra read beat %0d after the burst end", test_name, r_beat);
                    note_error();
                end
                if (rdata !== exp_data) begin
                    $display("ERROR %0s rdata beat %0d: expected %08h, actual %08h",
                             test_name, r_beat, exp_data, rdata);
                    note_error();
                end
                if (rid != r_id || rresp != exp_resp) begin
                    $display("ERROR %0s rid/rresp beat %0d: expected %0h/%0d, actual %0h/%0d",
                             test_name, r_beat, r_id, exp_resp, rid, rresp);
                    note_error();
                end
                if (rlast != (r_beat == int'(r_len))) begin
                    $display("ERROR %0s rlast beat %0d: expected %0b, actual %0b",
                             test_name, r_beat, r_beat == int'(r_len), rlast);
                    note_error();
                end
                r_beat++;
                if (r_burst == BURST_INCR) begin
                    r_addr = r_addr + ADDR_WID'(DATA_BYTE_WID);
                end
                if (rlast) begin
                    r_busy = 1'b0;
                    close_test();
                end
            end
        end
    end

    always @(posedge run_done) begin
        $display("Tests finished: %0d, errors: %0d", tests_done, error_count);
    end

endmodule : axi3_mem_checker

// ==== hw/axi3_mem.sv ====
module axi3_mem (
    input  logic                                axi3_if,
    input  logic                                srst,

    input  logic                                awvalid,
    output logic                                awready,
    input  logic [axi3_pkg::ID_WID-1:0]         awid,
    input  logic [axi3_pkg::ADDR_WID-1:0]       awaddr,
    input  logic [axi3_pkg::LEN_WID-1:0]        awlen,
    input  axi3_pkg::axburst_t                  awburst,

    input  logic                                wvalid,
    output logic                                wready,
    input  logic [axi3_pkg::ID_WID-1:0]         wid,
    input  logic [axi3_pkg::DATA_WID-1:0]       wdata,
    input  logic [axi3_pkg::DATA_BYTE_WID-1:0]  wstrb,
    input  logic                                wlast,

    output logic                                bvalid,
    input  logic                                bready,
    output logic [axi3_pkg::ID_WID-1:0]         bid,
    output axi3_pkg::resp_t                     bresp,

    input  logic                                arvalid,
    output logic                                arready,
    input  logic [axi3_pkg::ID_WID-1:0]         arid,
    input  logic [axi3_pkg::ADDR_WID-1:0]       araddr,
    input  logic [axi3_pkg::LEN_WID-1:0]        arlen,
    input  axi3_pkg::axburst_t                  arburst,

    output logic                                rvalid,
    input  logic                                rready,
    output logic [axi3_pkg::ID_WID-1:0]         rid,
    output logic [axi3_pkg::DATA_WID-1:0]       rdata,
    output axi3_pkg::resp_t                     rresp,
    output logic                                rlast
);

    import axi3_pkg::*;

    logic                     ram_we;
    logic [MEM_IDX_WID-1:0]   ram_widx;
    logic [DATA_WID-1:0]      ram_wdata;
    logic [DATA_BYTE_WID-1:0] ram_wstrb;
    logic                     ram_re;
    logic [MEM_IDX_WID-1:0]   ram_ridx;
    logic [DATA_WID-1:0]      ram_rdata;

    axi3_wr_path axi3_wr_path_inst (
        .axi3_if   (axi3_if),
        .srst      (srst),
        .awvalid   (awvalid),
        .awready   (awready),
        .awid      (awid),
        .awaddr    (awaddr),
        .awlen     (awlen),
        .awburst   (awburst),
        .wvalid    (wvalid),
        .wready    (wready),
        .wid       (wid),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wlast     (wlast),
        .bvalid    (bvalid),
        .bready    (bready),
        .bid       (bid),
        .bresp     (bresp),
        .ram_we    (ram_we),
        .ram_widx  (ram_widx),
        .ram_wdata (ram_wdata),
        .ram_wstrb (ram_wstrb)
    );

    axi3_rd_path axi3_rd_path_inst (
        .axi3_if   (axi3_if),
        .srst      (srst),
        .arvalid   (arvalid),
        .arready   (arready),
        .arid      (arid),
        .araddr    (araddr),
        .arlen     (arlen),
        .arburst   (arburst),
        .rvalid    (rvalid),
        .rready    (rready),
        .rid       (rid),
        .rdata     (rdata),
        .rresp     (rresp),
        .rlast     (rlast),
        .ram_re    (ram_re),
        .ram_ridx  (ram_ridx),
        .ram_rdata (ram_rdata)
    );

    axi3_mem_ram axi3_mem_ram_inst (
        .axi3_if   (axi3_if),
        .ram_we    (ram_we),
        .ram_widx  (ram_widx),
        .ram_wdata (ram_wdata),
        .ram_wstrb (ram_wstrb),
        .ram_re    (ram_re),
        .ram_ridx  (ram_ridx),
        .ram_rdata (ram_rdata)
    );

endmodule : axi3_mem

// ==== hw/axi3_rd_path.sv ====
module axi3_rd_path (
    input  logic                                axi3_if,
    input  logic                                srst,

    // AR channel
    input  logic                                arvalid,
    output logic                                arready,
    input  logic [axi3_pkg::ID_WID-1:0]         arid,
    input  logic [axi3_pkg::ADDR_WID-1:0]       araddr,
    input  logic [axi3_pkg::LEN_WID-1:0]        arlen,
    input  axi3_pkg::axburst_t                  arburst,

    // R channel
    output logic                                rvalid,
    input  logic                                rready,
    output logic [axi3_pkg::ID_WID-1:0]         rid,
    output logic [axi3_pkg::DATA_WID-1:0]       rdata,
    output axi3_pkg::resp_t                     rresp,
    output logic                                rlast,

    // RAM read port
    output logic                                ram_re,
    output logic [axi3_pkg::MEM_IDX_WID-1:0]    ram_ridx,
    input  logic [axi3_pkg::DATA_WID-1:0]       ram_rdata
);

    import axi3_pkg::*;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_DELAY,
        RD_STREAM
    } rd_state_t;

    rd_state_t              state;

    logic [ID_WID-1:0]      id_q;
    logic [ADDR_WID-1:0]    addr_q;
    logic [LEN_WID-1:0]     len_q;
    axburst_t               burst_q;
    resp_t                  resp_q;
    logic [LAT_CNT_WID-1:0] lat_cnt;

    logic [LEN_WID-1:0]     issue_cnt;
    logic                   issue_done;
    logic                   rd_pend;
    logic                   rd_pend_last;

    // Two-entry output buffer, pointers carry a wrap bit
    logic [DATA_WID-1:0]    buf_data [2];
    logic                   buf_last [2];
    logic [1:0]             wr_ptr;
    logic [1:0]             rd_ptr;
    // Buffered beats plus the read in flight
    logic [1:0]             occ_cnt;

    logic                   ar_hs;
    logic                   r_hs;

    assign arready = (state == RD_IDLE);
    assign rvalid  = (wr_ptr != rd_ptr);

    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;

    assign rid   = id_q;
    assign rresp = resp_q;
    assign rdata = buf_data[rd_ptr[0]];
    assign rlast = buf_last[rd_ptr[0]];

    // A slot freed by this cycle's pop is usable by the next returning read
    assign ram_re   = (state == RD_STREAM) && !issue_done && ((occ_cnt < 2'd2) || r_hs);
    assign ram_ridx = addr_q[BYTE_SEL_WID +: MEM_IDX_WID];

    always_ff @(posedge axi3_if) begin
        if (srst) begin
            state <= RD_IDLE;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (ar_hs) state <= RD_DELAY;
                end
                RD_DELAY: begin
                    if (lat_cnt == '0) state <= RD_STREAM;
                end
                RD_STREAM: begin
                    if (r_hs && rlast) state <= RD_IDLE;
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge axi3_if) begin
        if (srst) begin
            issue_done <= 1'b0;
            rd_pend    <= 1'b0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            occ_cnt    <= '0;
        end else begin
            rd_pend <= ram_re;
            if (ar_hs) begin
                issue_done <= 1'b0;
            end else if (ram_re && issue_cnt == len_q) begin
                issue_done <= 1'b1;
            end
            if (rd_pend) wr_ptr <= wr_ptr + 2'd1;
            if (r_hs) rd_ptr <= rd_ptr + 2'd1;
            case ({ram_re, r_hs})
                2'b10:   occ_cnt <= occ_cnt + 2'd1;
                2'b01:   occ_cnt <= occ_cnt - 2'd1;
                default: occ_cnt <= occ_cnt;
            endcase
        end
    end

    // Request context, latency wait and beat generation
    always_ff @(posedge axi3_if) begin
        if (ar_hs) begin
            id_q      <= arid;
            addr_q    <= araddr;
            len_q     <= arlen;
            burst_q   <= arburst;
            issue_cnt <= '0;
            lat_cnt   <= LAT_CNT_WID'(RD_LATENCY - 2);
            if (arburst == BURST_FIXED || arburst == BURST_INCR) begin
                resp_q <= RESP_OKAY;
            end else begin
                resp_q <= RESP_SLVERR;
            end
        end else if (state == RD_DELAY) begin
            lat_cnt <= lat_cnt - LAT_CNT_WID'(1);
        end
        if (ram_re) begin
            issue_cnt    <= issue_cnt + LEN_WID'(1);
            rd_pend_last <= (issue_cnt == len_q);
            if (burst_q == BURST_INCR) begin
                addr_q <= addr_q + ADDR_WID'(DATA_BYTE_WID);
            end
        end
    end

    // RAM data lands one cycle after the read, zeroed for refused bursts
    always_ff @(posedge axi3_if) begin
        if (rd_pend) begin
            buf_data[wr_ptr[0]] <= (resp_q == RESP_OKAY) ? ram_rdata : '0;
            buf_last[wr_ptr[0]] <= rd_pend_last;
        end
    end

    a_r_stable: assert property (
        @(posedge axi3_if) disable iff (srst)
        (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rlast)
                                 && $stable(rid) && $stable(rresp))
    );

    // Returning data always finds a free slot
    a_buf_no_overflow: assert property (
        @(posedge axi3_if) disable iff (srst)
        rd_pend |-> (2'(wr_ptr - rd_ptr) < 2'd2)
    );

endmodule : axi3_rd_path

// ==== hw/axi3_wr_path.sv ====
module axi3_wr_path (
    input  logic                                axi3_if,
    input  logic                                srst,

    // AW channel
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [axi3_pkg::ID_WID-1:0]         awid,
    input  logic [axi3_pkg::ADDR_WID-1:0]       awaddr,
    input  logic [axi3_pkg::LEN_WID-1:0]        awlen,
    input  axi3_pkg::axburst_t                  awburst,

    // W channel
    input  logic                                wvalid,
    output logic                                wready,
    input  logic [axi3_pkg::ID_WID-1:0]         wid,
    input  logic [axi3_pkg::DATA_WID-1:0]       wdata,
    input  logic [axi3_pkg::DATA_BYTE_WID-1:0]  wstrb,
    input  logic                                wlast,

    // B channel
    output logic                                bvalid,
    input  logic                                bready,
    output logic [axi3_pkg::ID_WID-1:0]         bid,
    output axi3_pkg::resp_t                     bresp,

    // RAM write port
    output logic                                ram_we,
    output logic [axi3_pkg::MEM_IDX_WID-1:0]    ram_widx,
    output logic [axi3_pkg::DATA_WID-1:0]       ram_wdata,
    output logic [axi3_pkg::DATA_BYTE_WID-1:0]  ram_wstrb
);

    import axi3_pkg::*;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_DELAY,
        WR_RESP
    } wr_state_t;

    wr_state_t              state;

    logic [ID_WID-1:0]      id_q;
    logic [ADDR_WID-1:0]    addr_q;
    logic [LEN_WID-1:0]     len_q;
    axburst_t               burst_q;
    resp_t                  resp_q;
    logic [LEN_WID-1:0]     beat_cnt;
    logic [LAT_CNT_WID-1:0] lat_cnt;

    logic                   aw_hs;
    logic                   w_hs;
    logic                   b_hs;

    assign awready = (state == WR_IDLE);
    assign wready  = (state == WR_DATA);
    assign bvalid  = (state == WR_RESP);

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign b_hs  = bvalid && bready;

    assign bid   = id_q;
    assign bresp = resp_q;

    // Refused bursts still take their beats but leave the RAM alone
    assign ram_we    = w_hs && (resp_q == RESP_OKAY);
    assign ram_widx  = addr_q[BYTE_SEL_WID +: MEM_IDX_WID];
    assign ram_wdata = wdata;
    assign ram_wstrb = wstrb;

    always_ff @(posedge axi3_if) begin
        if (srst) begin
            state <= WR_IDLE;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (aw_hs) state <= WR_DATA;
                end
                WR_DATA: begin
                    if (w_hs && wlast) state <= WR_DELAY;
                end
                WR_DELAY: begin
                    if (lat_cnt == '0) state <= WR_RESP;
                end
                WR_RESP: begin
                    if (b_hs) state <= WR_IDLE;
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // Burst context, address stepping and counters
    always_ff @(posedge axi3_if) begin
        if (aw_hs) begin
            id_q     <= awid;
            addr_q   <= awaddr;
            len_q    <= awlen;
            burst_q  <= awburst;
            beat_cnt <= '0;
            if (awburst == BURST_FIXED || awburst == BURST_INCR) begin
                resp_q <= RESP_OKAY;
            end else begin
                resp_q <= RESP_SLVERR;
            end
        end
        if (w_hs) begin
            beat_cnt <= beat_cnt + LEN_WID'(1);
            if (burst_q == BURST_INCR) begin
                addr_q <= addr_q + ADDR_WID'(DATA_BYTE_WID);
            end
        end
        // Two cycles of the latency come from the state transitions
        if (w_hs && wlast) begin
            lat_cnt <= LAT_CNT_WID'(WR_LATENCY - 2);
        end else if (state == WR_DELAY) begin
            lat_cnt <= lat_cnt - LAT_CNT_WID'(1);
        end
    end

    a_wid_match: assert property (
        @(posedge axi3_if) disable iff (srst)
        w_hs |-> (wid == id_q)
    );

    a_wlast_on_final_beat: assert property (
        @(posedge axi3_if) disable iff (srst)
        w_hs |-> (wlast == (beat_cnt == len_q))
    );

    // B payload held under back-pressure
    a_b_stable: assert property (
        @(posedge axi3_if) disable iff (srst)
        (bvalid && !bready) |=> (bvalid && $stable(bid) && $stable(bresp))
    );

endmodule : axi3_wr_path

// ==== hw/axi3_mem_ram.sv ====
module axi3_mem_ram (
    input  logic                                axi3_if,

    // Write port
    input  logic                                ram_we,
    input  logic [axi3_pkg::MEM_IDX_WID-1:0]    ram_widx,
    input  logic [axi3_pkg::DATA_WID-1:0]       ram_wdata,
    input  logic [axi3_pkg::DATA_BYTE_WID-1:0]  ram_wstrb,

    // Read port
    input  logic                                ram_re,
    input  logic [axi3_pkg::MEM_IDX_WID-1:0]    ram_ridx,
    output logic [axi3_pkg::DATA_WID-1:0]       ram_rdata
);

    import axi3_pkg::*;

    logic [DATA_BYTE_WID-1:0][7:0] mem [MEM_WORDS];

    // Byte lanes written independently
    always_ff @(posedge axi3_if) begin
        if (ram_we) begin
            for (int i = 0; i < DATA_BYTE_WID; i++) begin
                if (ram_wstrb[i]) begin
                    mem[ram_widx][i] <= ram_wdata[i*8 +: 8];
                end
            end
        end
    end

    // Output register holds its value while no read is issued
    always_ff @(posedge axi3_if) begin
        if (ram_re) begin
            ram_rdata <= mem[ram_ridx];
        end
    end

endmodule : axi3_mem_ram

// ==== hw/axi3_pkg.sv ====
package axi3_pkg;

    // Address and data bus geometry
    localparam int ADDR_WID = 16;
    localparam int DATA_BYTE_WID = 4;
    localparam int DATA_WID = DATA_BYTE_WID * 8;
    localparam int BYTE_SEL_WID = 2;
    localparam int ID_WID = 4;
    localparam int LEN_WID = 4;

    // Word RAM, upper address bits alias onto the index
    localparam int MEM_WORDS = 1024;
    localparam int MEM_IDX_WID = 10;

    // Response latencies in clock cycles, both must be at least 2
    localparam int WR_LATENCY = 8;
    localparam int RD_LATENCY = 8;

    // Wide enough for either latency minus two
    localparam int LAT_CNT_WID = 4;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axburst_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_t;

endpackage : axi3_pkg
